// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_int_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST RESULT: PASS
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sources.f ====
src/rv_isa_pkg.sv
src/ctrl_map_pkg.sv
src/pipe_stage.sv
src/instr_decoder.sv
src/reg_file.sv
src/exec_unit.sv
src/ctrl_regs.sv
src/int_core_top.sv
tb/int_core_properties.sv
tb/tb_int_core.sv

// ==== src/ctrl_map_pkg.sv ====
package ctrl_map_pkg;

  localparam int apb_addr_width = 8;
  localparam int apb_data_width = 32;

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_addr_width-1:0] paddr;
    logic [apb_data_width-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [apb_data_width-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

  // register map
  localparam logic [apb_addr_width-1:0] addr_ctrl     = 8'h00; // bit 0 run
  localparam logic [apb_addr_width-1:0] addr_retired  = 8'h04; // ro
  localparam logic [apb_addr_width-1:0] addr_illegal  = 8'h08; // ro
  localparam logic [apb_addr_width-1:0] addr_reg_sel  = 8'h0C;
  localparam logic [apb_addr_width-1:0] addr_reg_data = 8'h10; // ro

endpackage

// ==== src/ctrl_regs.sv ====
`timescale 1ns/1ps

module ctrl_regs (
  input  logic                               clk,
  input  logic                               rst_n,
  input  ctrl_map_pkg::apb_req_t             apb_req,
  output ctrl_map_pkg::apb_rsp_t             apb_rsp,
  input  logic                               retire_valid,
  input  logic                               retire_illegal,
  input  logic [rv_isa_pkg::xlen-1:0]        dbg_value,
  output logic                               run,
  output logic [rv_isa_pkg::regno_width-1:0] dbg_regno
);

  logic [ctrl_map_pkg::apb_data_width-1:0] retired_count;
  logic [ctrl_map_pkg::apb_data_width-1:0] illegal_count;
  logic [ctrl_map_pkg::apb_data_width-1:0] rdata;
  logic                                    access;
  logic                                    mapped;
  logic                                    read_only;
  logic                                    wr_ok;

  assign access = apb_req.psel && apb_req.penable;

  // address decode
  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    rdata     = '0;
    case (apb_req.paddr)
      ctrl_map_pkg::addr_ctrl:    rdata = {31'b0, run};
      ctrl_map_pkg::addr_retired: begin
        rdata     = retired_count;
        read_only = 1'b1;
      end
      ctrl_map_pkg::addr_illegal: begin
        rdata     = illegal_count;
        read_only = 1'b1;
      end
      ctrl_map_pkg::addr_reg_sel: rdata = {27'b0, dbg_regno};
      ctrl_map_pkg::addr_reg_data: begin
        rdata     = dbg_value;
        read_only = 1'b1;
      end
      default: mapped = 1'b0;
    endcase
  end

  // bad writes get pslverr and no update
  assign wr_ok = access && apb_req.pwrite && mapped && !read_only;

  always_comb begin
    apb_rsp.pready  = access; // no wait states
    apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && read_only));
    apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : '0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run       <= 1'b0;
      dbg_regno <= '0;
    end else if (wr_ok) begin
      if (apb_req.paddr == ctrl_map_pkg::addr_ctrl) run <= apb_req.pwdata[0];
      if (apb_req.paddr == ctrl_map_pkg::addr_reg_sel) dbg_regno <= apb_req.pwdata[4:0];
    end
  end

  // free-running counters, wrap at 2^32
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retired_count <= '0;
      illegal_count <= '0;
    end else if (retire_valid) begin
      retired_count <= retired_count + 1'b1;
      if (retire_illegal) illegal_count <= illegal_count + 1'b1;
    end
  end

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
  input  rv_isa_pkg::decoded_t               op,
  input  logic                               op_valid,
  input  logic                               ready, // run bit, ends the back-pressure chain
  output logic                               wr_en,
  output logic [rv_isa_pkg::regno_width-1:0] wr_regno,
  output logic [rv_isa_pkg::xlen-1:0]        wr_value,
  output rv_isa_pkg::retire_t                retire,
  output logic                               retire_valid
);

  logic [rv_isa_pkg::xlen-1:0] a;
  logic [rv_isa_pkg::xlen-1:0] b;
  logic [4:0]                  shamt;
  logic [rv_isa_pkg::xlen-1:0] result;
  logic                        writes;

  assign a     = op.use_pc ? op.pc : op.rs1_value;
  assign b     = op.use_imm ? op.imm : op.rs2_value;
  assign shamt = b[4:0];

  always_comb begin
    case (op.alu_op)
      rv_isa_pkg::alu_add:      result = a + b;
      rv_isa_pkg::alu_sub:      result = a - b;
      rv_isa_pkg::alu_sll:      result = a << shamt;
      rv_isa_pkg::alu_slt:      result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv_isa_pkg::alu_sltu:     result = (a < b) ? 32'd1 : 32'd0;
      rv_isa_pkg::alu_xor:      result = a ^ b;
      rv_isa_pkg::alu_srl:      result = a >> shamt;
      rv_isa_pkg::alu_sra:      result = $unsigned($signed(a) >>> shamt);
      rv_isa_pkg::alu_or:       result = a | b;
      rv_isa_pkg::alu_and:      result = a & b;
      rv_isa_pkg::alu_pass_imm: result = op.imm; // lui
      default:                  result = '0;
    endcase
  end

  assign writes       = op.wr_en && !op.illegal && op.rd != '0;
  assign retire_valid = op_valid && ready;

  assign wr_en    = retire_valid && writes;
  assign wr_regno = op.rd;
  assign wr_value = result;

  always_comb begin
    retire.pc      = op.pc;
    retire.rd      = op.rd;
    retire.value   = result;
    retire.wr_en   = writes;
    retire.illegal = op.illegal;
  end

endmodule

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
  input  rv_isa_pkg::fetch_t                 fetch,
  input  logic [rv_isa_pkg::xlen-1:0]        rs1_value,
  input  logic [rv_isa_pkg::xlen-1:0]        rs2_value,
  output logic [rv_isa_pkg::regno_width-1:0] rs1_regno,
  output logic [rv_isa_pkg::regno_width-1:0] rs2_regno,
  output rv_isa_pkg::decoded_t               decoded
);

  logic [6:0]                  opcode;
  logic [2:0]                  funct3;
  logic [6:0]                  funct7;
  logic [rv_isa_pkg::xlen-1:0] imm_i;
  logic [rv_isa_pkg::xlen-1:0] imm_u;

  // alt selects sub / sra where the encoding allows it
  function automatic rv_isa_pkg::alu_op_e op_from_funct3(input logic [2:0] f3,
                                                         input logic       alt);
    case (f3)
      rv_isa_pkg::f3_add_sub: return alt ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
      rv_isa_pkg::f3_sll:     return rv_isa_pkg::alu_sll;
      rv_isa_pkg::f3_slt:     return rv_isa_pkg::alu_slt;
      rv_isa_pkg::f3_sltu:    return rv_isa_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:     return rv_isa_pkg::alu_xor;
      rv_isa_pkg::f3_srl_sra: return alt ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
      rv_isa_pkg::f3_or:      return rv_isa_pkg::alu_or;
      default:                return rv_isa_pkg::alu_and;
    endcase
  endfunction

  assign opcode    = fetch.instr[6:0];
  assign funct3    = fetch.instr[14:12];
  assign funct7    = fetch.instr[31:25];
  assign rs1_regno = fetch.instr[19:15];
  assign rs2_regno = fetch.instr[24:20];

  assign imm_i = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
  assign imm_u = {fetch.instr[31:12], 12'b0};

  always_comb begin
    decoded           = '0;
    decoded.pc        = fetch.pc;
    decoded.rs1_value = rs1_value;
    decoded.rs2_value = rs2_value;
    decoded.rd        = fetch.instr[11:7];
    decoded.alu_op    = rv_isa_pkg::alu_add;
    decoded.wr_en     = 1'b1;
    case (opcode)
      rv_isa_pkg::opc_lui: begin
        decoded.imm     = imm_u;
        decoded.use_imm = 1'b1;
        decoded.alu_op  = rv_isa_pkg::alu_pass_imm;
      end
      rv_isa_pkg::opc_auipc: begin
        decoded.imm     = imm_u;
        decoded.use_imm = 1'b1;
        decoded.use_pc  = 1'b1; // pc + imm
      end
      rv_isa_pkg::opc_op_imm: begin
        decoded.imm     = imm_i;
        decoded.use_imm = 1'b1;
        decoded.alu_op  = op_from_funct3(funct3,
                                         funct3 == rv_isa_pkg::f3_srl_sra && funct7[5]);
        // shifts carry funct7 in the upper immediate bits
        if (funct3 == rv_isa_pkg::f3_sll && funct7 != rv_isa_pkg::f7_base)
          decoded.illegal = 1'b1;
        if (funct3 == rv_isa_pkg::f3_srl_sra && funct7 != rv_isa_pkg::f7_base &&
            funct7 != rv_isa_pkg::f7_alt)
          decoded.illegal = 1'b1;
      end
      rv_isa_pkg::opc_op: begin
        decoded.alu_op = op_from_funct3(funct3, funct7[5]);
        if (funct7 != rv_isa_pkg::f7_base && funct7 != rv_isa_pkg::f7_alt)
          decoded.illegal = 1'b1;
        if (funct7 == rv_isa_pkg::f7_alt && funct3 != rv_isa_pkg::f3_add_sub &&
            funct3 != rv_isa_pkg::f3_srl_sra)
          decoded.illegal = 1'b1; // only sub and sra have an alt form
      end
      default: decoded.illegal = 1'b1;
    endcase
    if (decoded.illegal) decoded.wr_en = 1'b0;
  end

endmodule

// ==== src/int_core_top.sv ====
`timescale 1ns/1ps

module int_core_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_isa_pkg::fetch_t     fetch_in,
  input  logic                   fetch_valid,
  output logic                   fetch_ready,
  output rv_isa_pkg::retire_t    retire,
  output logic                   retire_valid,
  input  ctrl_map_pkg::apb_req_t apb_req,
  output ctrl_map_pkg::apb_rsp_t apb_rsp
);

  rv_isa_pkg::fetch_t                 f0_data;
  logic                               f0_valid;
  logic                               f0_in_ready;
  rv_isa_pkg::decoded_t               decoded;
  rv_isa_pkg::decoded_t               d0_data;
  logic                               d0_valid;
  logic                               d0_in_ready;
  logic [rv_isa_pkg::regno_width-1:0] rs1_regno;
  logic [rv_isa_pkg::regno_width-1:0] rs2_regno;
  logic [rv_isa_pkg::xlen-1:0]        rs1_value;
  logic [rv_isa_pkg::xlen-1:0]        rs2_value;
  logic                               wr_en;
  logic [rv_isa_pkg::regno_width-1:0] wr_regno;
  logic [rv_isa_pkg::xlen-1:0]        wr_value;
  logic                               run;
  logic [rv_isa_pkg::regno_width-1:0] dbg_regno;
  logic [rv_isa_pkg::xlen-1:0]        dbg_value;

  assign fetch_ready = f0_in_ready && run; // no intake while stopped

  pipe_stage #(.payload_t(rv_isa_pkg::fetch_t)) f0 (
    .clk, .rst_n,
    .in_data(fetch_in), .in_valid(fetch_valid && run), .in_ready(f0_in_ready),
    .out_data(f0_data), .out_valid(f0_valid), .out_ready(d0_in_ready)
  );

  instr_decoder dec (
    .fetch(f0_data), .rs1_value, .rs2_value, .rs1_regno, .rs2_regno, .decoded
  );

  reg_file rf (
    .clk, .rst_n, .rs1_regno, .rs2_regno, .dbg_regno,
    .wr_en, .wr_regno, .wr_value, .rs1_value, .rs2_value, .dbg_value
  );

  pipe_stage #(.payload_t(rv_isa_pkg::decoded_t)) d0 (
    .clk, .rst_n,
    .in_data(decoded), .in_valid(f0_valid), .in_ready(d0_in_ready),
    .out_data(d0_data), .out_valid(d0_valid), .out_ready(run)
  );

  exec_unit ex (
    .op(d0_data), .op_valid(d0_valid), .ready(run),
    .wr_en, .wr_regno, .wr_value, .retire, .retire_valid
  );

  ctrl_regs ctrl (
    .clk, .rst_n, .apb_req, .apb_rsp,
    .retire_valid, .retire_illegal(retire.illegal),
    .dbg_value, .run, .dbg_regno
  );

endmodule

// ==== src/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  // take a new item when empty or when the current one leaves
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready && in_valid) begin
      out_data <= in_data; // payload has no reset
    end
  end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [rv_isa_pkg::regno_width-1:0] rs1_regno,
  input  logic [rv_isa_pkg::regno_width-1:0] rs2_regno,
  input  logic [rv_isa_pkg::regno_width-1:0] dbg_regno,
  input  logic                               wr_en,
  input  logic [rv_isa_pkg::regno_width-1:0] wr_regno,
  input  logic [rv_isa_pkg::xlen-1:0]        wr_value,
  output logic [rv_isa_pkg::xlen-1:0]        rs1_value,
  output logic [rv_isa_pkg::xlen-1:0]        rs2_value,
  output logic [rv_isa_pkg::xlen-1:0]        dbg_value
);

  logic [rv_isa_pkg::xlen-1:0] regs [rv_isa_pkg::reg_count];

  // x0 reads zero, a same-cycle write to the register wins
  function automatic logic [rv_isa_pkg::xlen-1:0] read_port(
      input logic [rv_isa_pkg::regno_width-1:0] regno);
    if (regno == '0) return '0;
    if (wr_en && wr_regno == regno) return wr_value;
    return regs[regno];
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < rv_isa_pkg::reg_count; i++) regs[i] <= '0;
    end else if (wr_en && wr_regno != '0) begin
      regs[wr_regno] <= wr_value;
    end
  end

  always_comb begin
    rs1_value = read_port(rs1_regno);
    rs2_value = read_port(rs2_regno);
    dbg_value = read_port(dbg_regno);
  end

endmodule

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int xlen        = 32;
  localparam int regno_width = 5;
  localparam int reg_count   = 1 << regno_width;

  // major opcodes, instr[6:0]
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000; // sub / sra

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and,
    alu_pass_imm
  } alu_op_e;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
  } fetch_t;

  typedef struct packed {
    logic [xlen-1:0]        pc;
    logic [xlen-1:0]        rs1_value;
    logic [xlen-1:0]        rs2_value;
    logic [xlen-1:0]        imm;
    logic [regno_width-1:0] rd;
    alu_op_e                alu_op;
    logic                   use_imm; // operand b from imm
    logic                   use_pc;  // operand a from pc (auipc)
    logic                   wr_en;
    logic                   illegal;
  } decoded_t;

  typedef struct packed {
    logic [xlen-1:0]        pc;
    logic [regno_width-1:0] rd;
    logic [xlen-1:0]        value;
    logic                   wr_en;
    logic                   illegal;
  } retire_t;

endpackage

// ==== tb/int_core_properties.sv ====
`timescale 1ns/1ps

module int_core_properties (
  input logic                   clk,
  input logic                   rst_n,
  input rv_isa_pkg::fetch_t     fetch_in,
  input logic                   fetch_valid,
  input logic                   fetch_ready,
  input logic                   retire_valid,
  input logic                   run,
  input ctrl_map_pkg::apb_req_t apb_req,
  input ctrl_map_pkg::apb_rsp_t apb_rsp
);

  int unsigned fail_count = 0; // failed assertions so far
  logic [2:0]  in_flight;      // taken at the fetch port and not yet retired

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + {2'b0, fetch_valid && fetch_ready} - {2'b0, retire_valid};
    end
  end

  // an offered instruction stays put until it is taken
  valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_in))
    else begin
      fail_count++;
      $error("fetch_valid dropped or fetch_in changed before the transfer");
    end

  pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    apb_req.psel && apb_req.penable |-> apb_rsp.pready)
    else begin
      fail_count++;
      $error("pready low in an apb access phase");
    end

  // a retire needs run and an instruction taken in earlier
  retire_needs_run: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> run && in_flight != '0)
    else begin
      fail_count++;
      $error("retire_valid while stopped or with no instruction in flight");
    end

endmodule

bind int_core_top int_core_properties props (
  .clk, .rst_n, .fetch_in, .fetch_valid, .fetch_ready,
  .retire_valid, .run, .apb_req, .apb_rsp
);

// ==== tb/tb_int_core.sv ====
`timescale 1ns/1ps

module tb_int_core;

  localparam int n_instr     = 300;
  localparam int stall_at    = 150;
  localparam int stall_len   = 8;
  localparam int apb_xfers   = 90;
  localparam int cycle_limit = 4 * n_instr + 2 * apb_xfers + 64;

  logic                   clk = 1'b0;
  logic                   rst_n;
  rv_isa_pkg::fetch_t     fetch_in;
  logic                   fetch_valid;
  logic                   fetch_ready;
  rv_isa_pkg::retire_t    retire;
  logic                   retire_valid;
  ctrl_map_pkg::apb_req_t apb_req;
  ctrl_map_pkg::apb_rsp_t apb_rsp;

  logic [31:0]         lfsr = 32'hf9ad;
  logic [31:0]         model_regs [32];
  int unsigned         model_retired = 0;
  int unsigned         model_illegal = 0;
  rv_isa_pkg::retire_t expected [$]; // retire records in program order
  int unsigned         value_errors = 0;
  int unsigned         flow_errors = 0;
  int                  cycles = 0;
  logic [4:0]          last_rd;
  logic [31:0]         pc;

  int_core_top UUT (
    .clk, .rst_n, .fetch_in, .fetch_valid, .fetch_ready,
    .retire, .retire_valid, .apb_req, .apb_rsp
  );

  always #2 clk = ~clk;

  // galois lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic is_legal(input logic [31:0] instr);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = instr[31:25];
    f3 = instr[14:12];
    case (instr[6:0])
      rv_isa_pkg::opc_lui, rv_isa_pkg::opc_auipc: return 1'b1;
      rv_isa_pkg::opc_op_imm: begin
        if (f3 == 3'd1) return f7 == 7'h00;
        if (f3 == 3'd5) return f7 == 7'h00 || f7 == 7'h20;
        return 1'b1;
      end
      rv_isa_pkg::opc_op: return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      default: return 1'b0;
    endcase
  endfunction

  // rv32i result against the model register state
  function automatic logic [31:0] isa_value(input logic [31:0] instr, input logic [31:0] ipc);
    logic [6:0]  opc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_u;
    logic [4:0]  sh;
    logic        alt;
    opc   = instr[6:0];
    a     = model_regs[instr[19:15]];
    imm_u = {instr[31:12], 12'h000};
    b     = (opc == rv_isa_pkg::opc_op) ? model_regs[instr[24:20]]
                                        : {{20{instr[31]}}, instr[31:20]};
    sh    = b[4:0];
    alt   = instr[30];
    if (opc == rv_isa_pkg::opc_lui) return imm_u;
    if (opc == rv_isa_pkg::opc_auipc) return ipc + imm_u;
    case (instr[14:12])
      3'd0: return (opc == rv_isa_pkg::opc_op && alt) ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] legal_instr();
    logic [1:0]  kind;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        alt;
    logic [19:0] upper;
    logic [11:0] imm12;
    kind  = 2'(random_bits(2));
    f3    = 3'(random_bits(3));
    rd    = 5'(random_bits(5));
    rs1   = (random_bits(1) != 0) ? last_rd : 5'(random_bits(5)); // often a dependency
    rs2   = 5'(random_bits(5));
    alt   = random_bits(1) != 0;
    upper = 20'(random_bits(20));
    imm12 = 12'(random_bits(12));
    case (kind)
      2'd0: return {upper, rd, rv_isa_pkg::opc_lui};
      2'd1: return {upper, rd, rv_isa_pkg::opc_auipc};
      2'd2: begin
        if (f3 == 3'd1) imm12 = {7'b0, imm12[4:0]};
        else if (f3 == 3'd5) imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
        return {imm12, rs1, f3, rd, rv_isa_pkg::opc_op_imm};
      end
      default: return {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd,
                       rv_isa_pkg::opc_op};
    endcase
  endfunction

  function automatic logic [31:0] illegal_instr();
    logic [31:0] instr;
    instr = random_bits(32);
    while (is_legal(instr)) instr[6:0] = 7'(random_bits(7));
    return instr;
  endfunction

  // offer one instruction from a falling edge, update the model once taken
  task automatic send(input logic [31:0] instr);
    logic                accepted;
    rv_isa_pkg::retire_t want;
    fetch_in.pc    = pc;
    fetch_in.instr = instr;
    fetch_valid    = 1'b1;
    accepted       = 1'b0;
    while (!accepted) begin
      accepted = fetch_ready;
      @(negedge clk);
    end
    want.pc      = pc;
    want.rd      = instr[11:7];
    want.illegal = !is_legal(instr);
    want.value   = want.illegal ? '0 : isa_value(instr, pc);
    want.wr_en   = !want.illegal && want.rd != '0;
    if (want.wr_en) model_regs[want.rd] = want.value;
    model_retired++;
    if (want.illegal) model_illegal++;
    expected.push_back(want);
    last_rd = want.rd;
    pc += 4;
  endtask

  task automatic apb_check(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                           input logic [31:0] want_rdata, input logic want_err,
                           input string what);
    logic [31:0] rdata;
    logic        err;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    assert (err == want_err) else begin
      value_errors++;
      $display("FAILED %0t: %s pslverr %b, expected %b", $time, what, err, want_err);
    end
    if (!write && !want_err) begin
      assert (rdata == want_rdata) else begin
        value_errors++;
        $display("FAILED %0t: %s read %h, expected %h", $time, what, rdata, want_rdata);
      end
    end
  endtask

  // run clears while two instructions are in flight, then resumes
  task automatic stall_and_resume();
    logic [31:0] first;
    logic [31:0] second;
    first  = legal_instr();
    second = legal_instr();
    fork
      apb_check(1'b1, ctrl_map_pkg::addr_ctrl, 32'h0, 32'h0, 1'b0, "run clear");
      begin
        send(first);
        send(second);
      end
    join
    fetch_valid = 1'b0;
    repeat (stall_len) begin
      assert (!fetch_ready && !retire_valid) else begin
        flow_errors++;
        $display("pipeline kept moving at %0t while run was clear", $time);
      end
      @(negedge clk);
    end
    apb_check(1'b1, ctrl_map_pkg::addr_ctrl, 32'h1, 32'h0, 1'b0, "run set");
  endtask

  // retire records are checked in the low clock phase, where they are stable
  always @(negedge clk) begin
    rv_isa_pkg::retire_t want;
    if (rst_n && retire_valid) begin
      if (expected.size() == 0) begin
        flow_errors++;
        $display("retire at %0t with no instruction outstanding", $time);
      end else begin
        want = expected.pop_front();
        assert (retire.pc == want.pc && retire.illegal == want.illegal &&
                retire.wr_en == want.wr_en) else begin
          value_errors++;
          $display("FAILED %0t: retire pc %h illegal %b wr_en %b, expected %h %b %b", $time,
                   retire.pc, retire.illegal, retire.wr_en, want.pc, want.illegal, want.wr_en);
        end
        if (!want.illegal) begin
          assert (retire.rd == want.rd && retire.value == want.value) else begin
            value_errors++;
            $display("FAILED %0t: pc %h wrote x%0d = %h, expected x%0d = %h", $time,
                     retire.pc, retire.rd, retire.value, want.rd, want.value);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    logic [31:0] instr;
    int          gap;
    rst_n       = 1'b0;
    fetch_in    = '0;
    fetch_valid = 1'b0;
    apb_req     = '0;
    pc          = 32'h0000_1000;
    last_rd     = '0;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    assert (!fetch_ready && !retire_valid) else begin
      flow_errors++;
      $display("fetch_ready or retire_valid high after reset");
    end
    apb_check(1'b0, ctrl_map_pkg::addr_ctrl, 32'h0, 32'h0, 1'b0, "ctrl after reset");
    apb_check(1'b1, ctrl_map_pkg::addr_ctrl, 32'h1, 32'h0, 1'b0, "run set");
    assert (fetch_ready) else begin
      flow_errors++;
      $display("fetch_ready stayed low after run was set");
    end

    for (int i = 0; i < n_instr; i++) begin
      if (i == stall_at) stall_and_resume();
      instr = (random_bits(3) == 0) ? illegal_instr() : legal_instr();
      send(instr);
      gap = int'(random_bits(2));
      if (gap == 3) gap = 0;
      if (gap > 0) begin
        fetch_valid = 1'b0;
        repeat (gap) @(negedge clk);
      end
    end
    fetch_valid = 1'b0;
    while (expected.size() != 0) @(negedge clk);
    @(negedge clk);

    apb_check(1'b0, ctrl_map_pkg::addr_retired, 32'h0, model_retired, 1'b0, "retired count");
    apb_check(1'b0, ctrl_map_pkg::addr_illegal, 32'h0, model_illegal, 1'b0, "illegal count");
    for (int r = 0; r < 32; r++) begin
      apb_check(1'b1, ctrl_map_pkg::addr_reg_sel, 32'(r), 32'h0, 1'b0, "reg_sel");
      apb_check(1'b0, ctrl_map_pkg::addr_reg_data, 32'h0, model_regs[r], 1'b0, "reg_data");
    end

    // bad accesses, then the state must be unchanged
    apb_check(1'b0, 8'h20, 32'h0, 32'h0, 1'b1, "unmapped read");
    apb_check(1'b1, 8'h24, 32'h0, 32'h0, 1'b1, "unmapped write");
    apb_check(1'b1, ctrl_map_pkg::addr_retired, 32'h5a5a, 32'h0, 1'b1, "retired write");
    apb_check(1'b1, ctrl_map_pkg::addr_illegal, 32'h5a5a, 32'h0, 1'b1, "illegal write");
    apb_check(1'b1, ctrl_map_pkg::addr_reg_data, 32'h5a5a, 32'h0, 1'b1, "reg_data write");
    apb_check(1'b0, ctrl_map_pkg::addr_ctrl, 32'h0, 32'h1, 1'b0, "ctrl kept");
    apb_check(1'b0, ctrl_map_pkg::addr_retired, 32'h0, model_retired, 1'b0, "retired kept");
    apb_check(1'b0, ctrl_map_pkg::addr_illegal, 32'h0, model_illegal, 1'b0, "illegal kept");
    apb_check(1'b0, ctrl_map_pkg::addr_reg_sel, 32'h0, 32'd31, 1'b0, "reg_sel kept");
    apb_check(1'b0, ctrl_map_pkg::addr_reg_data, 32'h0, model_regs[31], 1'b0, "x31 kept");

    $display("errors: %0d value, %0d flow, %0d assertion", value_errors, flow_errors,
             UUT.props.fail_count);
    if (value_errors + flow_errors + UUT.props.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
